//--- common/jenc_pkg.sv
`default_nettype none

package jenc_pkg;

    localparam int coef_w     = 12;
    localparam int qcoef_w    = 11;
    localparam int recip_w    = 16;
    localparam int code_w     = 20;
    localparam int len_w      = 5;
    localparam int acc_w      = 32;
    localparam int blk_size   = 64;
    localparam int num_tables = 4;

    // all ones acts as a step of one, exact for every 12-bit magnitude after rounding
    localparam logic [recip_w-1:0] recip_one = '1;

    localparam logic [7:0] sym_zrl = 8'hF0;   // sixteen zeros
    localparam logic [7:0] sym_eob = 8'h00;   // rest of block is zero

    // quantizer to coder
    typedef struct packed {
        logic signed [qcoef_w-1:0] q;
        logic [5:0]                pos;   // zigzag index within the block
        logic                      last;  // last coefficient of the image
    } qcoef_t;

    // coder to packer
    typedef struct packed {
        logic [code_w-1:0] bits;   // left aligned, unused low bits are zero
        logic [len_w-1:0]  len;
        logic              last;   // final code of the image
    } code_t;

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     arst_n,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_hold,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_hold
);

logic load;

// stalls only when the held item cannot leave this cycle
assign in_hold = out_valid & out_hold;
assign load    = in_valid & ~in_hold;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        out_valid <= 1'b0;
    end else if (!in_hold) begin
        out_valid <= in_valid;
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        out_data <= in_data;
    end
end

endmodule

`default_nettype wire

//--- hdl/quant_table.sv
`timescale 1ns/1ps
`default_nettype none

module quant_table
    import jenc_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,

    input  logic               cfg_we,
    input  logic [7:0]         cfg_addr,    // table in [7:6], zigzag index in [5:0]
    input  logic [recip_w-1:0] cfg_data,

    input  logic [1:0]         rd_table,
    input  logic [5:0]         rd_pos,
    output logic [recip_w-1:0] rd_recip
);

logic [recip_w-1:0] tbl [num_tables][blk_size];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int t = 0; t < num_tables; t++) begin
            for (int p = 0; p < blk_size; p++) begin
                tbl[t][p] <= recip_one;
            end
        end
    end else if (cfg_we) begin
        tbl[cfg_addr[7:6]][cfg_addr[5:0]] <= cfg_data;
    end
end

assign rd_recip = tbl[rd_table][rd_pos];   // combinational, new entry visible the cycle after a write

a_cfg_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    cfg_we |-> !$isunknown(cfg_addr)
) else $error("table write with unknown address");

endmodule

`default_nettype wire

//--- quant/quant.sv
`timescale 1ns/1ps
`default_nettype none

module quant
    import jenc_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic signed [coef_w-1:0] in_coef,
    input  logic                     in_valid,
    input  logic                     in_tlast,
    output logic                     in_hold,

    input  logic [1:0]               qf_select,

    output logic [1:0]               rd_table,
    output logic [5:0]               rd_pos,
    input  logic [recip_w-1:0]       rd_recip,

    output qcoef_t                   out_q,
    output logic                     out_valid,
    input  logic                     out_hold
);

logic                          accept;
logic [5:0]                    pos;
logic                          first;       // next coefficient starts an image
logic [1:0]                    tsel;
logic [coef_w-1:0]             mag;
logic [coef_w+recip_w-1:0]     prod;
logic [coef_w-1:0]             qmag;
logic [qcoef_w-1:0]            clip;
logic signed [qcoef_w-1:0]     qval;

assign in_hold  = out_valid & out_hold;
assign accept   = in_valid & ~in_hold;
assign rd_table = first ? qf_select : tsel;
assign rd_pos   = pos;

always_comb begin
    mag  = in_coef[coef_w-1] ? -in_coef : in_coef;
    prod = mag * rd_recip + (coef_w+recip_w)'(2 ** (recip_w-1));   // round half up
    qmag = prod[coef_w+recip_w-1:recip_w];
    clip = (qmag > coef_w'(2**(qcoef_w-1)-1)) ? qcoef_w'(2**(qcoef_w-1)-1) : qcoef_w'(qmag);
    qval = in_coef[coef_w-1] ? -$signed(clip) : $signed(clip);
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        out_valid <= 1'b0;
        pos       <= '0;
        first     <= 1'b1;
        tsel      <= '0;
    end else begin
        if (!in_hold) out_valid <= in_valid;
        if (accept) begin
            pos   <= in_tlast ? 6'd0 : pos + 6'd1;   // wraps at 63 on its own
            first <= in_tlast;
            if (first) tsel <= qf_select;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        out_q.q    <= qval;
        out_q.pos  <= pos;
        out_q.last <= in_tlast;
    end
end

a_in_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (in_valid && in_hold) |=> (in_valid && $stable(in_coef) && $stable(in_tlast))
) else $error("quantizer input changed while held");

endmodule

`default_nettype wire

//--- entropy/rle_coder.sv
`timescale 1ns/1ps
`default_nettype none

module rle_coder
    import jenc_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    input  qcoef_t in_q,
    input  logic   in_valid,
    output logic   in_hold,

    output code_t  out_code,
    output logic   out_valid,
    input  logic   out_hold
);

// number of significant bits of the magnitude
function automatic logic [3:0] size_of(input logic signed [coef_w-1:0] v);
    logic [coef_w-1:0] m;
    logic [3:0]        s;
    m = v[coef_w-1] ? -v : v;
    s = 4'd0;
    for (int i = 0; i < coef_w; i++) begin
        if (m[i]) s = 4'(i + 1);
    end
    return s;
endfunction

logic signed [qcoef_w-1:0] prev_dc;
logic [5:0]                run;         // zeros since the last coded coefficient
logic                      ready;
logic                      step;
logic                      accept;
logic                      emit;
logic                      is_dc;
logic                      nz;
logic                      end_blk;
logic                      take_zrl;
logic signed [coef_w-1:0]  diff;
logic signed [coef_w-1:0]  val;
logic signed [coef_w-1:0]  amp;
logic [3:0]                sz;
logic [7:0]                head;
logic [len_w-1:0]          head_len;
logic [len_w-1:0]          amp_len;
logic [code_w-1:0]         raw;
code_t                     code;

assign is_dc    = in_q.pos == 6'd0;
assign nz       = in_q.q != '0;
assign end_blk  = (in_q.pos == 6'(blk_size-1)) || in_q.last;
assign ready    = ~(out_valid & out_hold);
assign take_zrl = in_valid & ~is_dc & nz & (run >= 6'd16);   // input stays put meanwhile
assign in_hold  = ~ready | take_zrl;
assign step     = in_valid & ready;
assign accept   = in_valid & ~in_hold;
assign emit     = step & (is_dc | nz | end_blk);   // zeros inside a block only count

always_comb begin
    diff = $signed(in_q.q) - prev_dc;
    val  = is_dc ? diff : coef_w'($signed(in_q.q));
    sz   = size_of(val);
    amp  = (val < 0) ? val - 1 : val;   // ones' complement form for negatives

    if (is_dc) begin
        head     = {4'd0, sz};
        head_len = len_w'(4);
        amp_len  = len_w'(sz);
    end else if (take_zrl) begin
        head     = sym_zrl;
        head_len = len_w'(8);
        amp_len  = '0;
    end else if (nz) begin
        head     = {run[3:0], sz};
        head_len = len_w'(8);
        amp_len  = len_w'(sz);
    end else begin
        head     = sym_eob;   // pending ZRLs are dropped
        head_len = len_w'(8);
        amp_len  = '0;
    end

    raw       = (code_w'(head) << amp_len) | (code_w'(amp) & ~({code_w{1'b1}} << amp_len));
    code.len  = head_len + amp_len;
    code.bits = raw << (code_w - code.len);
    code.last = in_q.last & ~take_zrl;
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        out_valid <= 1'b0;
        run       <= '0;
        prev_dc   <= '0;
    end else begin
        if (ready) out_valid <= emit;
        if (step) begin
            if (take_zrl) begin
                run <= run - 6'd16;
            end else if (is_dc || nz || end_blk) begin
                run <= '0;
            end else begin
                run <= run + 6'd1;
            end
        end
        if (accept) begin
            if (in_q.last) begin
                prev_dc <= '0;   // next image starts from zero
            end else if (is_dc) begin
                prev_dc <= in_q.q;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (emit) begin
        out_code <= code;
    end
end

endmodule

`default_nettype wire

//--- packer/bitpacker.sv
`timescale 1ns/1ps
`default_nettype none

module bitpacker
    import jenc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  code_t       in_code,
    input  logic        in_valid,
    output logic        in_hold,

    output logic [7:0]  out_byte,
    output logic        out_valid,
    output logic        out_tlast,
    input  logic        out_hold,

    output logic [19:0] size
);

logic [acc_w-1:0]             acc;          // MSB first, bits below fill are zero
logic [$clog2(acc_w+1)-1:0]   fill;
logic [$clog2(acc_w+1)-1:0]   fill_n;
logic [acc_w-1:0]             acc_n;
logic                         flushing;     // last code is in, drain and pad
logic                         stuff_pend;   // 0x00 owed after a 0xFF
logic                         take;
logic                         out_ready;
logic                         pop;
logic                         xfer;
logic                         cand_valid;
logic                         cand_last;
logic [7:0]                   cand_byte;
logic [19:0]                  byte_cnt;

assign in_hold   = flushing | (fill > acc_w - code_w);
assign take      = in_valid & ~in_hold;
assign out_ready = ~(out_valid & out_hold);
assign pop       = cand_valid & out_ready;
assign xfer      = out_valid & ~out_hold;

always_comb begin
    cand_valid = stuff_pend | (fill >= 8) | (flushing & (fill != '0));
    cand_byte  = 8'h00;
    if (!stuff_pend) begin
        cand_byte = acc[acc_w-1 -: 8];
        if (fill < 8) cand_byte = cand_byte | (8'hFF >> fill);   // pad the tail with ones
    end
    cand_last = flushing & (stuff_pend ? (fill == '0) : ((fill <= 8) && (cand_byte != 8'hFF)));
end

always_comb begin
    acc_n  = acc;
    fill_n = fill;
    if (pop && !stuff_pend) begin
        acc_n  = acc << 8;
        fill_n = (fill >= 8) ? fill - 6'd8 : '0;
    end
    if (take) begin
        acc_n  = acc_n | ({in_code.bits, {(acc_w-code_w){1'b0}}} >> fill_n);
        fill_n = fill_n + in_code.len;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        acc        <= '0;
        fill       <= '0;
        flushing   <= 1'b0;
        stuff_pend <= 1'b0;
        out_valid  <= 1'b0;
        out_tlast  <= 1'b0;
        byte_cnt   <= '0;
        size       <= '0;
    end else begin
        acc  <= acc_n;
        fill <= fill_n;
        if (take && in_code.last) begin
            flushing <= 1'b1;
        end else if (pop && cand_last) begin
            flushing <= 1'b0;
        end
        if (pop) stuff_pend <= ~stuff_pend & (cand_byte == 8'hFF);
        if (out_ready) begin
            out_valid <= cand_valid;
            out_tlast <= cand_valid & cand_last;
        end
        if (xfer) begin
            if (out_tlast) begin
                size     <= byte_cnt + 20'd1;   // stuffed bytes are counted too
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 20'd1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (pop) begin
        out_byte <= cand_byte;
    end
end

a_fill_bound: assert property (
    @(posedge clk) disable iff (!arst_n)
    take |=> (fill <= acc_w)
) else $error("bit accumulator overflow");

endmodule

`default_nettype wire

//--- hdl/jenc.sv
`timescale 1ns/1ps
`default_nettype none

module jenc
    import jenc_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic signed [coef_w-1:0] in_coef,
    input  logic                     in_valid,
    output logic                     in_hold,
    input  logic                     in_tlast,

    output logic [7:0]               out_byte,
    output logic                     out_valid,
    output logic                     out_tlast,
    input  logic                     out_hold,

    input  logic [1:0]               qf_select,   // sampled at the start of each image
    input  logic                     cfg_we,
    input  logic [7:0]               cfg_addr,
    input  logic [recip_w-1:0]       cfg_data,

    output logic [19:0]              size
);

logic [1:0]         rd_table;
logic [5:0]         rd_pos;
logic [recip_w-1:0] rd_recip;

qcoef_t             q_data;
logic               q_valid;
logic               q_hold;
qcoef_t             qr_data;
logic               qr_valid;
logic               qr_hold;

code_t              c_data;
logic               c_valid;
logic               c_hold;
code_t              cr_data;
logic               cr_valid;
logic               cr_hold;

quant_table u_quant_table (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_data  (cfg_data),
    .rd_table  (rd_table),
    .rd_pos    (rd_pos),
    .rd_recip  (rd_recip)
);

quant u_quant (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_coef   (in_coef),
    .in_valid  (in_valid),
    .in_tlast  (in_tlast),
    .in_hold   (in_hold),
    .qf_select (qf_select),
    .rd_table  (rd_table),
    .rd_pos    (rd_pos),
    .rd_recip  (rd_recip),
    .out_q     (q_data),
    .out_valid (q_valid),
    .out_hold  (q_hold)
);

pipe_reg #(.payload_t(qcoef_t)) u_q_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (q_data),
    .in_valid  (q_valid),
    .in_hold   (q_hold),
    .out_data  (qr_data),
    .out_valid (qr_valid),
    .out_hold  (qr_hold)
);

rle_coder u_rle_coder (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_q      (qr_data),
    .in_valid  (qr_valid),
    .in_hold   (qr_hold),
    .out_code  (c_data),
    .out_valid (c_valid),
    .out_hold  (c_hold)
);

pipe_reg #(.payload_t(code_t)) u_c_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (c_data),
    .in_valid  (c_valid),
    .in_hold   (c_hold),
    .out_data  (cr_data),
    .out_valid (cr_valid),
    .out_hold  (cr_hold)
);

bitpacker u_bitpacker (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_code   (cr_data),
    .in_valid  (cr_valid),
    .in_hold   (cr_hold),
    .out_byte  (out_byte),
    .out_valid (out_valid),
    .out_tlast (out_tlast),
    .out_hold  (out_hold),
    .size      (size)
);

endmodule

`default_nettype wire

//--- sim/jenc_model.svh
`ifndef JENC_MODEL_SVH
`define JENC_MODEL_SVH

int unsigned lcg_state = 42;
int          model_tbl [num_tables][blk_size];   // copy of every table write
int          img_q [$];                          // coefficients of one image, zigzag order
bit          bit_q [$];
logic [7:0]  exp_q [$];                          // expected bytes of one image

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7FFF;
endfunction

function automatic int rand_below(input int n);
    return int'(lcg_next() % 32'(n));
endfunction

// magnitude times reciprocal, round half up, clip to the eleven-bit range
function automatic int quantize(input int coef, input int recip);
    longint mag;
    longint q;
    mag = (coef < 0) ? -coef : coef;
    q   = (mag * recip + 32768) >> 16;
    if (q > 1023) q = 1023;
    return (coef < 0) ? -int'(q) : int'(q);
endfunction

function automatic int bit_size(input int v);
    int m;
    int s;
    m = (v < 0) ? -v : v;
    s = 0;
    while (m > 0) begin
        s++;
        m = m >> 1;
    end
    return s;
endfunction

function automatic void push_bits(input int value, input int n);
    for (int i = n - 1; i >= 0; i--) begin
        bit_q.push_back(value[i]);
    end
endfunction

// negative values go out as the low bits of v-1, which is the ones' complement of |v|
function automatic void push_amp(input int v, input int sz);
    push_bits((v < 0) ? v - 1 : v, sz);
endfunction

function automatic void build_expected(input int tsel);
    int         prev_dc;
    int         run;
    int         q;
    int         sz;
    int         diff;
    logic [7:0] b;
    bit_q.delete();
    exp_q.delete();
    prev_dc = 0;
    run     = 0;
    for (int i = 0; i < img_q.size(); i++) begin
        q = quantize(img_q[i], model_tbl[tsel][i % blk_size]);
        if (i % blk_size == 0) begin
            diff    = q - prev_dc;
            prev_dc = q;
            sz      = bit_size(diff);
            push_bits(sz, 4);
            push_amp(diff, sz);
            run = 0;
        end else if (q == 0) begin
            if (i % blk_size == blk_size - 1) begin
                push_bits(sym_eob, 8);   // trailing zeros collapse into one symbol
            end else begin
                run++;
            end
        end else begin
            while (run >= 16) begin
                push_bits(sym_zrl, 8);
                run -= 16;
            end
            sz = bit_size(q);
            push_bits(run * 16 + sz, 8);
            push_amp(q, sz);
            run = 0;
        end
    end
    while (bit_q.size() % 8 != 0) begin
        bit_q.push_back(1'b1);
    end
    for (int i = 0; i < bit_q.size(); i += 8) begin
        b = '0;
        for (int j = 0; j < 8; j++) begin
            b = {b[6:0], bit_q[i + j]};
        end
        exp_q.push_back(b);
        if (b == 8'hFF) exp_q.push_back(8'h00);
    end
endfunction

`endif

//--- sim/jenc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module jenc_tb
    import jenc_pkg::*;
();

localparam int wait_limit = 5000;   // cycles without progress before giving up

logic                     clk;
logic                     arst_n;
logic signed [coef_w-1:0] in_coef;
logic                     in_valid;
logic                     in_hold;
logic                     in_tlast;
logic [7:0]               out_byte;
logic                     out_valid;
logic                     out_tlast;
logic                     out_hold;
logic [1:0]               qf_select;
logic                     cfg_we;
logic [7:0]               cfg_addr;
logic [recip_w-1:0]       cfg_data;
logic [19:0]              size;

int errors;
int tests_run;
int tests_failed;
bit hung;
int gap_pct;
int hold_pct;
int last_size;

`include "jenc_model.svh"

jenc u_jenc (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_coef   (in_coef),
    .in_valid  (in_valid),
    .in_hold   (in_hold),
    .in_tlast  (in_tlast),
    .out_byte  (out_byte),
    .out_valid (out_valid),
    .out_tlast (out_tlast),
    .out_hold  (out_hold),
    .qf_select (qf_select),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_data  (cfg_data),
    .size      (size)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

task automatic load_table(input int t, input int max_step);
    int step;
    int recip;
    for (int p = 0; p < blk_size; p++) begin
        step  = 1 + rand_below(max_step);
        recip = (65536 + step / 2) / step;
        if (recip > 65535) recip = 65535;
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_addr <= 8'(t * blk_size + p);
        cfg_data <= recip_w'(recip);
        model_tbl[t][p] = recip;
    end
    @(posedge clk);
    cfg_we <= 1'b0;
endtask

function automatic void random_image(input int nblocks);
    int r;
    img_q.delete();
    for (int i = 0; i < nblocks * blk_size; i++) begin
        r = rand_below(100);
        if (i % blk_size == 0 || r >= 90) begin
            img_q.push_back(rand_below(4095) - 2047);
        end else if (r < 65) begin
            img_q.push_back(0);
        end else begin
            img_q.push_back(rand_below(61) - 30);
        end
    end
endfunction

function automatic void zero_image(input int nblocks);
    img_q.delete();
    repeat (nblocks * blk_size) img_q.push_back(0);
endfunction

task automatic drive_image();
    int cnt;
    int gaps;
    bit accepted;
    for (int i = 0; i < img_q.size() && !hung; i++) begin
        gaps = 0;
        while (gaps < 8 && rand_below(100) < gap_pct) begin
            in_valid <= 1'b0;
            @(posedge clk);
            gaps++;
        end
        in_valid <= 1'b1;
        in_coef  <= coef_w'(img_q[i]);
        in_tlast <= (i == img_q.size() - 1);
        accepted = 1'b0;
        cnt      = 0;
        while (!accepted && !hung) begin
            @(negedge clk);
            accepted = !in_hold;   // transfer happens on the coming edge
            @(posedge clk);
            cnt++;
            if (!accepted && cnt >= wait_limit) begin
                $display("timeout: input held for %0d cycles at coefficient %0d", cnt, i);
                hung = 1'b1;
            end
        end
    end
    in_valid <= 1'b0;
    in_tlast <= 1'b0;
endtask

task automatic collect_image();
    int idx;
    int idle;
    bit done;
    bit hold_next;
    idx       = 0;
    idle      = 0;
    done      = 1'b0;
    hold_next = 1'b0;
    while (!done && !hung) begin
        @(posedge clk);
        out_hold <= hold_next;
        @(negedge clk);
        hold_next = (rand_below(100) < hold_pct);   // hold for the next cycle
        if (out_valid && !out_hold) begin
            idle = 0;
            if (idx >= exp_q.size()) begin
                $display("CHECK FAILED at %0t: extra byte %02h after %0d expected bytes",
                         $time, out_byte, exp_q.size());
                errors++;
            end else if (out_byte !== exp_q[idx]) begin
                $display("CHECK FAILED at %0t: byte %0d is %02h, expected %02h",
                         $time, idx, out_byte, exp_q[idx]);
                errors++;
            end
            if (out_tlast !== 1'(idx == exp_q.size() - 1)) begin
                $display("CHECK FAILED at %0t: out_tlast is %b on byte %0d of %0d",
                         $time, out_tlast, idx, exp_q.size());
                errors++;
            end
            if (out_tlast) done = 1'b1;
            idx++;
            if (idx > exp_q.size() + 4) begin
                $display("output kept running past the end of the image");
                hung = 1'b1;
            end
        end else begin
            idle++;
            if (idle >= wait_limit) begin
                $display("timeout: no output byte for %0d cycles after byte %0d", idle, idx);
                hung = 1'b1;
            end
        end
    end
    @(posedge clk);
    out_hold <= 1'b0;
    @(negedge clk);   // size has taken the count by now
    if (!hung && size !== 20'(exp_q.size())) begin
        $display("CHECK FAILED at %0t: size is %0d, expected %0d", $time, size, exp_q.size());
        errors++;
    end
    last_size = int'(size);
endtask

task automatic run_image(input int qsel);
    build_expected(qsel);
    @(posedge clk);
    qf_select <= 2'(qsel);
    fork
        drive_image();
        collect_image();
    join
endtask

task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before || hung) begin
        tests_failed++;
        $display("test %s: FAIL", name);
    end else begin
        $display("test %s: ok", name);
    end
endtask

initial begin
    int err_before;
    int qsel;
    int saved_sel;
    int saved_size;
    int saved_q [$];
    arst_n    = 1'b0;
    in_coef   = '0;
    in_valid  = 1'b0;
    in_tlast  = 1'b0;
    out_hold  = 1'b0;
    qf_select = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hung         = 1'b0;
    for (int t = 0; t < num_tables; t++) begin
        for (int p = 0; p < blk_size; p++) begin
            model_tbl[t][p] = 65535;
        end
    end
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    err_before = errors;
    repeat (16) begin
        @(negedge clk);
        if (out_valid !== 1'b0 || out_tlast !== 1'b0 || size !== 20'd0 || in_hold !== 1'b0) begin
            $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
            errors++;
        end
    end
    for (int t = 0; t < num_tables; t++) begin
        load_table(t, (t == 0) ? 1 : 8 << t);   // table 0 is step one everywhere
    end
    report_test("reset state", err_before);

    err_before = errors;
    if (size !== 20'd0) begin
        $display("CHECK FAILED at %0t: size is %0d before the first image", $time, size);
        errors++;
    end
    gap_pct  = 30;
    hold_pct = 30;
    for (int k = 0; k < 3 && !hung; k++) begin
        random_image(1 + rand_below(2));
        qsel = rand_below(num_tables);
        run_image(qsel);
    end
    saved_q    = img_q;
    saved_sel  = qsel;
    saved_size = last_size;
    report_test("random images", err_before);

    if (!hung) begin
        err_before = errors;
        zero_image(2);
        img_q[0]   = 100;
        img_q[21]  = 50;    // run of 20
        img_q[40]  = -7;    // run of 18 and 23 trailing zeros
        img_q[64]  = -40;
        img_q[81]  = 3;     // run of exactly 16
        img_q[127] = -9;    // run of 45 into the last position
        run_image(0);
        report_test("zero runs", err_before);
    end

    if (!hung) begin
        err_before = errors;
        zero_image(1);
        img_q[0]  = 12;     // four-bit DC code puts the amplitude on a byte boundary
        img_q[16] = 1023;
        run_image(0);
        if (exp_q.size() < 4 || exp_q[2] != 8'hFF || exp_q[3] != 8'h00) begin
            $display("stuffing block gave no 0xFF byte in the expected stream");
            errors++;
        end
        report_test("byte stuffing", err_before);
    end

    if (!hung) begin
        err_before = errors;
        gap_pct  = 60;
        hold_pct = 75;
        img_q    = saved_q;
        run_image(saved_sel);
        if (!hung && last_size != saved_size) begin
            $display("CHECK FAILED at %0t: size %0d differs from the earlier run %0d",
                     $time, last_size, saved_size);
            errors++;
        end
        report_test("back-pressure", err_before);
    end

    if (!hung) begin
        err_before = errors;
        gap_pct  = 20;
        hold_pct = 20;
        load_table(2, 40);
        random_image(1);
        run_image(2);
        report_test("table rewrite", err_before);
    end

    $display("tests run %0d, tests with errors %0d, check failures %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && !hung) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- jenc.f
+incdir+sim
common/jenc_pkg.sv
hdl/pipe_reg.sv
hdl/quant_table.sv
quant/quant.sv
entropy/rle_coder.sv
packer/bitpacker.sv
hdl/jenc.sv
sim/jenc_tb.sv
